// File: run_sim.sh
#!/bin/sh
# build and run the execute slice testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_alu_exec -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_alu_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// File: sources.f
+incdir+verilog
verilog/rv_alu_pkg.sv
verilog/alu_ctrl_if.sv
verilog/alu_res_if.sv
verilog/alu_decode.sv
verilog/alu_execute.sv
verilog/alu_result.sv
verilog/alu_exec_top.sv
verif/tb_alu_exec.sv

// File: verif/tb_alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_alu_params.svh"

module tb_alu_exec;
    import rv_alu_pkg::*;

    // expected response of one item
    typedef struct packed {
        logic                  err;
        logic                  is_br;
        logic                  we;
        logic [`ALU_REG_W-1:0] rd;
        logic [`ALU_XLEN-1:0]  data;
        logic                  zero;
        logic                  taken;
        logic [`ALU_XLEN-1:0]  target;
    } exp_t;

    // r-type funct3/funct7 pairs in the order add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic [6:0] R_F7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                         7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    // addi slti sltiu xori ori andi, then slli srli srai
    localparam logic [2:0] I_F3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6,
                                        3'd7, 3'd1, 3'd5, 3'd5};
    // beq bne blt bge bltu bgeu
    localparam logic [2:0] B_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // corner operands
    // last pair is signed-less but unsigned-greater
    localparam logic [31:0] CORNER_A [4] = '{32'h0, 32'hffffffff, 32'h80000000, 32'hfffffff0};
    localparam logic [31:0] CORNER_B [4] = '{32'h0, 32'h1, 32'h7fffffff, 32'h00000010};

    localparam int R_PAIRS        = 8;
    localparam int I_PAIRS        = 4;
    localparam int N_STREAM       = 20;
    localparam int N_BP           = 60;
    localparam int TOTAL_ITEMS    = 10 * R_PAIRS + 9 * I_PAIRS + 6 * 4 + 5 + N_STREAM + N_BP;
    localparam int TIMEOUT_CYCLES = TOTAL_ITEMS * 12 + 200;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    instr_u                instr;
    logic [`ALU_XLEN-1:0]  pc;
    logic [`ALU_XLEN-1:0]  rs1_data;
    logic [`ALU_XLEN-1:0]  rs2_data;
    logic                  out_valid;
    logic                  out_ready;
    logic                  rd_we;
    logic [`ALU_REG_W-1:0] rd_addr;
    logic [`ALU_XLEN-1:0]  rd_data;
    logic                  br_taken;
    logic [`ALU_XLEN-1:0]  br_target;
    logic                  zero;
    logic                  err;

    // scoreboard state
    exp_t  exp_q[$];
    int    acc_q[$];
    int    cycle = 0;
    int    n_acc = 0;
    int    n_out = 0;
    int    n_checks = 0;
    int    n_errors = 0;
    int    test_chk0;
    int    test_err0;
    int    stall_cycles = 0;
    int    last_out = 0;
    logic  stream_chk = 1'b0;
    logic  stream_first = 1'b0;
    logic  bp_mode = 1'b0;
    string cur_test = "reset";

    // separate lfsr states for stimulus and for out_ready
    logic [15:0] data_lfsr = 16'd64677;
    logic [15:0] ready_lfsr = 16'd64677;

    alu_exec_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .instr     (instr),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rd_we     (rd_we),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .br_taken  (br_taken),
        .br_target (br_target),
        .zero      (zero),
        .err       (err)
    );

    always #10 clk = ~clk;

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hb400;
        return n;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], data_lfsr[0]};
            data_lfsr = lfsr_step(data_lfsr);
        end
        return v;
    endfunction

    function automatic instr_u r_word(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd);
        instr_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = 5'd2;
        w.r_fmt.rs1    = 5'd1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = `ALU_OPC_OP;
        return w;
    endfunction

    function automatic instr_u i_word(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rd);
        instr_u w;
        w.i_fmt.imm    = imm;
        w.i_fmt.rs1    = 5'd1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = `ALU_OPC_OPIMM;
        return w;
    endfunction

    // off is the 13-bit byte offset whose bit 0 is dropped
    function automatic instr_u b_word(input logic [12:0] off, input logic [2:0] f3);
        instr_u w;
        w.b_fmt.imm12   = off[12];
        w.b_fmt.imm10_5 = off[10:5];
        w.b_fmt.rs2     = 5'd2;
        w.b_fmt.rs1     = 5'd1;
        w.b_fmt.funct3  = f3;
        w.b_fmt.imm4_1  = off[4:1];
        w.b_fmt.imm11   = off[11];
        w.b_fmt.opcode  = `ALU_OPC_BRANCH;
        return w;
    endfunction

    // reference model straight from the isa rules
    function automatic exp_t model(input instr_u w, input logic [31:0] p,
                                   input logic [31:0] a, input logic [31:0] b);
        exp_t        e;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] opnd;
        logic [31:0] off;
        logic        alt;
        logic        ok;
        logic        slt;
        opc  = w[6:0];
        f3   = w[14:12];
        f7   = w[31:25];
        e    = '0;
        e.rd = w[11:7];
        ok   = 1'b1;
        alt  = 1'b0;
        opnd = b;
        if (opc == `ALU_OPC_OP)
        begin
            ok  = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
            alt = f7[5];
        end
        else if (opc == `ALU_OPC_OPIMM)
        begin
            opnd = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'd1)
                ok = (f7 == 7'h00);
            if (f3 == 3'd5)
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            alt = (f3 == 3'd5) && f7[5];
        end
        // signed less from the sign bits or an unsigned compare when signs match
        slt = (a[31] != opnd[31]) ? a[31] : (a < opnd);
        if (opc == `ALU_OPC_OP || opc == `ALU_OPC_OPIMM)
        begin
            case (f3)
                3'd0:    e.data = alt ? a - opnd : a + opnd;
                3'd1:    e.data = a << opnd[4:0];
                3'd2:    e.data = {31'd0, slt};
                3'd3:    e.data = {31'd0, a < opnd};
                3'd4:    e.data = a ^ opnd;
                // sra as srl with the vacated bits filled by the sign
                3'd5:    e.data = (a >> opnd[4:0]) |
                                  ((alt && a[31]) ? ~(32'hffffffff >> opnd[4:0]) : 32'h0);
                3'd6:    e.data = a | opnd;
                default: e.data = a & opnd;
            endcase
            e.zero = (e.data == 32'h0);
            e.we   = ok && (e.rd != 5'd0);
        end
        else if (opc == `ALU_OPC_BRANCH)
        begin
            e.is_br  = 1'b1;
            off      = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            e.target = p + off;
            e.zero   = (a == b);
            case (f3)
                3'd0:    e.taken = (a == b);
                3'd1:    e.taken = (a != b);
                3'd4:    e.taken = slt;
                3'd5:    e.taken = !slt;
                3'd6:    e.taken = (a < b);
                3'd7:    e.taken = (a >= b);
                default: ok = 1'b0;
            endcase
            if (!ok)
                e.taken = 1'b0;
        end
        else
        begin
            ok = 1'b0;
        end
        e.err = !ok;
        return e;
    endfunction

    task automatic check_val(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        n_checks++;
        assert (exp_v === act_v)
        else
        begin
            $display("ERROR %s: %s expected %h actual %h", cur_test, field, exp_v, act_v);
            n_errors++;
        end
    endtask

    task automatic check_out(input exp_t e);
        check_val("err", e.err, err);
        if (e.err)
        begin
            check_val("rd_we", 0, rd_we);
            check_val("br_taken", 0, br_taken);
        end
        else if (e.is_br)
        begin
            check_val("br_taken", e.taken, br_taken);
            check_val("br_target", e.target, br_target);
            check_val("rd_we", 0, rd_we);
            check_val("zero", e.zero, zero);
        end
        else
        begin
            check_val("rd_we", e.we, rd_we);
            check_val("rd_data", e.data, rd_data);
            check_val("zero", e.zero, zero);
            check_val("br_taken", 0, br_taken);
            if (e.we)
                check_val("rd_addr", e.rd, rd_addr);
        end
    endtask

    // cycle count and run limit
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles in %s, results stopped arriving", cycle, cur_test);
            $display("Test failed");
            $finish;
        end
    end

    // random out_ready under back-pressure is high a quarter of the time
    always @(posedge clk)
    begin
        logic b0;
        logic b1;
        #1;
        if (bp_mode)
        begin
            b0 = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
            b1 = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
            out_ready = b0 & b1;
        end
        else
        begin
            out_ready = 1'b1;
        end
    end

    // handshakes sampled mid-cycle for transfers on the next edge
    always @(negedge clk)
    begin
        exp_t e;
        int   lat;
        if (!rst)
        begin
            if (!in_ready)
            begin
                stall_cycles++;
                assert (n_acc - n_out == 3)
                else
                begin
                    $display("%s: in_ready low with only %0d items in flight",
                             cur_test, n_acc - n_out);
                    n_errors++;
                end
            end
            if (in_valid && in_ready)
            begin
                exp_q.push_back(model(instr, pc, rs1_data, rs2_data));
                acc_q.push_back(cycle);
                n_acc++;
            end
            if (out_valid && out_ready)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    $display("%s: result came out with no item pending", cur_test);
                    n_errors++;
                end
                if (exp_q.size() != 0)
                begin
                    e = exp_q.pop_front();
                    lat = cycle - acc_q.pop_front();
                    check_out(e);
                    if (stream_chk)
                    begin
                        check_val("latency", 3, lat);
                        if (!stream_first)
                            check_val("result gap", 1, cycle - last_out);
                        stream_first = 1'b0;
                    end
                    last_out = cycle;
                    n_out++;
                end
            end
        end
    end

    // hold the item until accepted and return 1 ns after the accepting edge
    task automatic send_item(input instr_u w, input logic [31:0] p,
                             input logic [31:0] a, input logic [31:0] b);
        in_valid = 1'b1;
        instr    = w;
        pc       = p;
        rs1_data = a;
        rs2_data = b;
        do
            @(negedge clk);
        while (!in_ready);
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_chk0 = n_checks;
        test_err0 = n_errors;
    endtask

    // idle the input and wait until the pipeline is empty
    task automatic finish_test();
        in_valid = 1'b0;
        while (n_out != n_acc)
            @(posedge clk);
        #1;
        $display("%s: %0d checks, %0d errors", cur_test, n_checks - test_chk0,
                 n_errors - test_err0);
    endtask

    task automatic rand_item();
        logic [2:0] f3;
        logic       alt;
        f3  = 3'(rand_bits(3));
        alt = 1'(rand_bits(1));
        alt = alt && (f3 == 3'd0 || f3 == 3'd5);
        send_item(r_word(alt ? 7'h20 : 7'h00, f3, 5'(rand_bits(5))), 32'h0,
                  rand_bits(32), rand_bits(32));
    endtask

    task automatic rtype_ops();
        logic [31:0] a;
        logic [31:0] b;
        start_test("rtype");
        for (int k = 0; k < 10; k++)
        begin
            for (int j = 0; j < R_PAIRS; j++)
            begin
                a = (j < 4) ? CORNER_A[j] : rand_bits(32);
                b = (j < 4) ? CORNER_B[j] : rand_bits(32);
                send_item(r_word(R_F7[k], R_F3[k], 5'((k * R_PAIRS + j) % 31 + 1)), 32'h0, a, b);
            end
        end
        finish_test();
    endtask

    task automatic itype_ops();
        logic [11:0] imm;
        logic [31:0] a;
        start_test("itype");
        for (int k = 0; k < 9; k++)
        begin
            for (int j = 0; j < I_PAIRS; j++)
            begin
                // negative rs1 so srai and srli differ
                a = rand_bits(32) | 32'h80000000;
                if (k >= 6)
                    imm = {(k == 8) ? 7'h20 : 7'h00, 5'(rand_bits(5))};
                else if (j == 0)
                    imm = 12'hfff;
                else
                    imm = {1'b1, 11'(rand_bits(11))};
                send_item(i_word(imm, I_F3[k], 5'(k + j + 1)), 32'h0, a, rand_bits(32));
            end
        end
        finish_test();
    endtask

    task automatic branch_ops();
        logic [12:0] off;
        logic [31:0] p;
        start_test("branch");
        for (int k = 0; k < 6; k++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                off = {12'(rand_bits(12)), 1'b0};
                p   = {30'(rand_bits(30)), 2'b00};
                // equal, less, greater, then mixed signs
                case (j)
                    0:       send_item(b_word(off, B_F3[k]), p, 32'd5, 32'd5);
                    1:       send_item(b_word(off, B_F3[k]), p, 32'd3, 32'd9);
                    2:       send_item(b_word(off, B_F3[k]), p, 32'd9, 32'd3);
                    default: send_item(b_word(off, B_F3[k]), p, CORNER_A[3], CORNER_B[3]);
                endcase
            end
        end
        finish_test();
    endtask

    task automatic illegal_encodings();
        instr_u w;
        start_test("illegal");
        // load opcode is not handled
        w = r_word(7'h00, 3'd0, 5'd5);
        w.r_fmt.opcode = 7'b0000011;
        send_item(w, 32'h0, 32'd1, 32'd2);
        send_item(r_word(7'h01, 3'd0, 5'd6), 32'h0, 32'd1, 32'd2);
        send_item(i_word({7'h20, 5'd3}, 3'd1, 5'd7), 32'h0, 32'd1, 32'd2);
        // reserved branch funct3
        send_item(b_word(13'h10, 3'd2), 32'h100, 32'd1, 32'd1);
        // legal add to x0 without a write
        send_item(r_word(7'h00, 3'd0, 5'd0), 32'h0, 32'd1, 32'd2);
        finish_test();
    endtask

    task automatic streaming();
        start_test("stream");
        stream_chk   = 1'b1;
        stream_first = 1'b1;
        for (int k = 0; k < N_STREAM; k++)
            rand_item();
        finish_test();
        stream_chk = 1'b0;
    endtask

    task automatic back_pressure();
        int stall0;
        start_test("backpressure");
        stall0  = stall_cycles;
        bp_mode = 1'b1;
        for (int k = 0; k < N_BP; k++)
            rand_item();
        finish_test();
        bp_mode = 1'b0;
        assert (stall_cycles > stall0)
        else
        begin
            $display("%s: in_ready never fell while out_ready was low", cur_test);
            n_errors++;
        end
    endtask

    initial
    begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // idle state right after reset
        @(negedge clk);
        check_val("in_ready after reset", 1, in_ready);
        check_val("out_valid after reset", 0, out_valid);
        @(posedge clk);
        #1;
        rtype_ops();
        itype_ops();
        branch_ops();
        illegal_encodings();
        streaming();
        back_pressure();
        $display("%0d items, %0d checks, %0d errors", n_out, n_checks, n_errors);
        if (n_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_alu_params.svh"

// decode -> execute bundle
interface alu_ctrl_if;
    import rv_alu_pkg::*;

    // handshake
    logic valid;
    logic ready;

    // decoded operation and operands
    operation_t            op;
    logic [`ALU_XLEN-1:0]  op_a;
    logic [`ALU_XLEN-1:0]  op_b;

    // carried along for later stages
    logic [`ALU_REG_W-1:0] rd;
    logic [`ALU_XLEN-1:0]  pc;
    logic [`ALU_XLEN-1:0]  br_off;
    logic                  illegal;

    // decode side
    modport src (
        output valid, op, op_a, op_b, rd, pc, br_off, illegal,
        input  ready
    );

    // execute side
    modport dst (
        input  valid, op, op_a, op_b, rd, pc, br_off, illegal,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/alu_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_alu_params.svh"

module alu_decode (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  in_valid,
    output logic                       in_ready,
    input  wire rv_alu_pkg::instr_u    instr,
    input  wire logic [`ALU_XLEN-1:0]  pc,
    input  wire logic [`ALU_XLEN-1:0]  rs1_data,
    input  wire logic [`ALU_XLEN-1:0]  rs2_data,
    alu_ctrl_if.src                    ctrl
);
    import rv_alu_pkg::*;

    operation_t            op_d;
    logic [`ALU_XLEN-1:0]  op_b_d;
    logic [`ALU_REG_W-1:0] rd_d;
    logic                  illegal_d;
    logic [`ALU_XLEN-1:0]  imm_i;
    logic [`ALU_XLEN-1:0]  imm_b;
    logic                  f7_plain;
    logic                  f7_alt;
    logic                  f3_has_alt;
    logic                  accept;

    // funct3 + alternate bit -> alu op, shared by OP and OP-IMM
    function automatic operation_t f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    // funct7 and i-imm[11:5] sit on the same bits
    assign f7_plain   = (instr.r_fmt.funct7 == 7'b0000000);
    assign f7_alt     = (instr.r_fmt.funct7 == 7'b0100000);
    // only add/sub and srl/sra have a second flavour
    assign f3_has_alt = (instr.r_fmt.funct3 == 3'b000) || (instr.r_fmt.funct3 == 3'b101);

    // sign extended immediates
    assign imm_i = {{(`ALU_XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_b = {{(`ALU_XLEN-13){instr.b_fmt.imm12}}, instr.b_fmt.imm12,
                    instr.b_fmt.imm11, instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};

    always_comb
    begin
        op_d      = ADD;
        op_b_d    = rs2_data;
        rd_d      = instr.r_fmt.rd;
        illegal_d = 1'b0;
        case (instr.r_fmt.opcode)
            `ALU_OPC_OP:
            begin
                op_d      = f3_to_op(instr.r_fmt.funct3, f3_has_alt && f7_alt);
                illegal_d = !(f7_plain || (f3_has_alt && f7_alt));
            end
            `ALU_OPC_OPIMM:
            begin
                op_b_d = imm_i;
                // no SUBI, so bit 30 only matters for the right shifts
                op_d   = f3_to_op(instr.i_fmt.funct3,
                                  (instr.i_fmt.funct3 == 3'b101) && f7_alt);
                if (instr.i_fmt.funct3 == 3'b001)
                    illegal_d = !f7_plain;
                else if (instr.i_fmt.funct3 == 3'b101)
                    illegal_d = !(f7_plain || f7_alt);
            end
            `ALU_OPC_BRANCH:
            begin
                // branches have no destination
                rd_d = '0;
                case (instr.b_fmt.funct3)
                    BR_EQ:   op_d = BEQ;
                    BR_NE:   op_d = BNE;
                    BR_LT:   op_d = BLT;
                    BR_GE:   op_d = BGE;
                    BR_LTU:  op_d = BLTU;
                    BR_GEU:  op_d = BGEU;
                    default: illegal_d = 1'b1;
                endcase
            end
            default:
            begin
                illegal_d = 1'b1;
            end
        endcase
    end

    // empty, or the held item leaves this cycle
    assign in_ready = !ctrl.valid || ctrl.ready;
    assign accept   = in_valid && in_ready;

    // valid flag
    always_ff @(posedge clk)
    begin
        if (rst)
            ctrl.valid <= 1'b0;
        else if (accept)
            ctrl.valid <= 1'b1;
        else if (ctrl.ready)
            ctrl.valid <= 1'b0;
    end

    // payload, loaded on accept only
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            ctrl.op      <= op_d;
            ctrl.op_a    <= rs1_data;
            ctrl.op_b    <= op_b_d;
            ctrl.rd      <= rd_d;
            ctrl.pc      <= pc;
            ctrl.br_off  <= imm_b;
            ctrl.illegal <= illegal_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_alu_params.svh"

// decode -> execute -> result, one item per stage
// accept at edge n gives out_valid after n+2, out transfer at n+3
module alu_exec_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  in_valid,
    output logic                       in_ready,
    input  wire rv_alu_pkg::instr_u    instr,
    input  wire logic [`ALU_XLEN-1:0]  pc,
    input  wire logic [`ALU_XLEN-1:0]  rs1_data,
    input  wire logic [`ALU_XLEN-1:0]  rs2_data,
    output logic                       out_valid,
    input  wire logic                  out_ready,
    output logic                       rd_we,
    output logic [`ALU_REG_W-1:0]      rd_addr,
    output logic [`ALU_XLEN-1:0]       rd_data,
    output logic                       br_taken,
    output logic [`ALU_XLEN-1:0]       br_target,
    output logic                       zero,
    output logic                       err
);

    // stage links
    alu_ctrl_if ctrl_bus ();
    alu_res_if  res_bus ();

    alu_decode decode0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ctrl     (ctrl_bus.src)
    );

    alu_execute execute0 (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl_bus.dst),
        .res  (res_bus.src)
    );

    alu_result result0 (
        .clk       (clk),
        .rst       (rst),
        .res       (res_bus.dst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rd_we     (rd_we),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .br_taken  (br_taken),
        .br_target (br_target),
        .zero      (zero),
        .err       (err)
    );

endmodule

`default_nettype wire

// File: verilog/alu_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_alu_params.svh"

module alu_execute (
    input  wire logic clk,
    input  wire logic rst,
    alu_ctrl_if.dst   ctrl,
    alu_res_if.src    res
);
    import rv_alu_pkg::*;

    logic [`ALU_XLEN-1:0] alu_result;
    logic [`ALU_XLEN-1:0] diff;
    logic [4:0]           shamt;
    logic                 a_lt_s;
    logic                 a_lt_u;
    logic                 a_eq;
    logic                 eq_flag;
    logic                 less_flag;
    logic                 accept;

    // shared compare and subtract
    assign diff   = ctrl.op_a - ctrl.op_b;
    assign a_lt_s = $signed(ctrl.op_a) < $signed(ctrl.op_b);
    assign a_lt_u = ctrl.op_a < ctrl.op_b;
    assign a_eq   = (ctrl.op_a == ctrl.op_b);
    // low five bits of rs2 or shamt field
    assign shamt  = ctrl.op_b[4:0];

    always_comb
    begin
        alu_result = '0;
        eq_flag    = 1'b0;
        less_flag  = 1'b0;
        case (ctrl.op)
            ADD:  alu_result = ctrl.op_a + ctrl.op_b;
            SUB:  alu_result = diff;
            SLL:  alu_result = ctrl.op_a << shamt;
            SLT:  alu_result = {{(`ALU_XLEN-1){1'b0}}, a_lt_s};
            SLTU: alu_result = {{(`ALU_XLEN-1){1'b0}}, a_lt_u};
            XOR:  alu_result = ctrl.op_a ^ ctrl.op_b;
            SRL:  alu_result = ctrl.op_a >> shamt;
            // arithmetic shift keeps the sign bit
            SRA:  alu_result = $signed(ctrl.op_a) >>> shamt;
            OR:   alu_result = ctrl.op_a | ctrl.op_b;
            AND:  alu_result = ctrl.op_a & ctrl.op_b;
            // branches return a - b so zero flags equality
            BEQ, BNE:
            begin
                alu_result = diff;
                eq_flag    = a_eq;
            end
            BLT:
            begin
                alu_result = diff;
                less_flag  = a_lt_s;
            end
            BLTU:
            begin
                alu_result = diff;
                less_flag  = a_lt_u;
            end
            // ge forms flag less-or-equal plus equal, result stage combines them
            BGE:
            begin
                alu_result = diff;
                less_flag  = a_lt_s || a_eq;
                eq_flag    = a_eq;
            end
            BGEU:
            begin
                alu_result = diff;
                less_flag  = a_lt_u || a_eq;
                eq_flag    = a_eq;
            end
            default:
            begin
                alu_result = '0;
            end
        endcase
        // bad encoding, no result and no flags
        if (ctrl.illegal)
        begin
            alu_result = '0;
            eq_flag    = 1'b0;
            less_flag  = 1'b0;
        end
    end

    assign ctrl.ready = !res.valid || res.ready;
    assign accept     = ctrl.valid && ctrl.ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            res.valid <= 1'b0;
        else if (accept)
            res.valid <= 1'b1;
        else if (res.ready)
            res.valid <= 1'b0;
    end

    // registered alu outputs
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            res.op        <= ctrl.op;
            res.result    <= alu_result;
            res.zero_flag <= (alu_result == '0);
            res.eq_flag   <= eq_flag;
            res.less_flag <= less_flag;
            res.err_flag  <= ctrl.illegal;
            res.rd        <= ctrl.rd;
            res.pc        <= ctrl.pc;
            res.br_off    <= ctrl.br_off;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_res_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_alu_params.svh"

// execute -> result bundle
interface alu_res_if;
    import rv_alu_pkg::*;

    logic valid;
    logic ready;

    // alu output and flags
    operation_t            op;
    logic [`ALU_XLEN-1:0]  result;
    logic                  zero_flag;
    logic                  eq_flag;
    logic                  less_flag;
    logic                  err_flag;

    // passthrough for write-back and branch target
    logic [`ALU_REG_W-1:0] rd;
    logic [`ALU_XLEN-1:0]  pc;
    logic [`ALU_XLEN-1:0]  br_off;

    modport src (
        output valid, op, result, zero_flag, eq_flag, less_flag, err_flag, rd, pc, br_off,
        input  ready
    );

    modport dst (
        input  valid, op, result, zero_flag, eq_flag, less_flag, err_flag, rd, pc, br_off,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/alu_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_alu_params.svh"

module alu_result (
    input  wire logic                  clk,
    input  wire logic                  rst,
    alu_res_if.dst                     res,
    output logic                       out_valid,
    input  wire logic                  out_ready,
    output logic                       rd_we,
    output logic [`ALU_REG_W-1:0]      rd_addr,
    output logic [`ALU_XLEN-1:0]       rd_data,
    output logic                       br_taken,
    output logic [`ALU_XLEN-1:0]       br_target,
    output logic                       zero,
    output logic                       err
);
    import rv_alu_pkg::*;

    logic is_branch;
    logic taken;
    logic accept;

    // branch ops occupy the upper encodings
    assign is_branch = (res.op >= BEQ);

    // taken decision from the execute flags
    always_comb
    begin
        case (res.op)
            BEQ:        taken = res.eq_flag;
            BNE:        taken = !res.eq_flag;
            BLT, BLTU:  taken = res.less_flag;
            BGE, BGEU:  taken = !res.less_flag || res.eq_flag;
            default:    taken = 1'b0;
        endcase
    end

    assign res.ready = !out_valid || out_ready;
    assign accept    = res.valid && res.ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            out_valid <= 1'b0;
        else if (accept)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // write-back and branch outputs
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            // x0 is never written
            rd_we     <= !is_branch && !res.err_flag && (res.rd != '0);
            rd_addr   <= res.rd;
            rd_data   <= res.result;
            br_taken  <= is_branch && !res.err_flag && taken;
            br_target <= res.pc + res.br_off;
            zero      <= res.zero_flag;
            err       <= res.err_flag;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_alu_params.svh
`ifndef RV_ALU_PARAMS_SVH
`define RV_ALU_PARAMS_SVH

// datapath width for rv32i
`define ALU_XLEN 32

// register index width, x0..x31
`define ALU_REG_W 5

// major opcodes handled by the slice
// register-register alu ops
`define ALU_OPC_OP 7'b0110011
// register-immediate alu ops
`define ALU_OPC_OPIMM 7'b0010011
// conditional branches
`define ALU_OPC_BRANCH 7'b1100011

`endif

// File: verilog/rv_alu_pkg.sv
`default_nettype none

`include "rv_alu_params.svh"

package rv_alu_pkg;

    // alu operation with the branches in the upper encodings
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13,
        BLTU = 4'd14,
        BGEU = 4'd15
    } operation_t;

    // funct3 of the branch opcode
    // 3'b010 and 3'b011 are reserved
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_kind_t;

    // r format
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`ALU_REG_W-1:0] rs2;
        logic [`ALU_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`ALU_REG_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    // i format where imm[11:5] overlays funct7 for the shift forms
    typedef struct packed {
        logic [11:0]           imm;
        logic [`ALU_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`ALU_REG_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // b format with the immediate scattered across the word
    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [`ALU_REG_W-1:0] rs2;
        logic [`ALU_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    // one 32-bit word with three views picked by opcode
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
    } instr_u;

endpackage

`default_nettype wire
